//--- include/axi2iob_cfg.svh
/*
 * AXI4 to IOb adapter configuration
 * bus widths shared by the package and the testbench
 */
`ifndef AXI2IOB_CFG_SVH
`define AXI2IOB_CFG_SVH

// byte address width
`define AXI2IOB_ADDR_W 32
// data word width as a multiple of 8 bits
`define AXI2IOB_DATA_W 32
// AXI transaction ID width
`define AXI2IOB_ID_W 8

`endif

//--- src/axi2iob_pkg.sv
/*
 * AXI4 to IOb adapter types
 * bus field types and the FSM / grant encodings
 */
`include "axi2iob_cfg.svh"

package axi2iob_pkg;

   typedef logic [`AXI2IOB_ADDR_W-1:0]   addr_t;
   typedef logic [`AXI2IOB_DATA_W-1:0]   data_t;
   typedef logic [`AXI2IOB_DATA_W/8-1:0] strb_t;
   typedef logic [`AXI2IOB_ID_W-1:0]     id_t;
   // burst length minus one
   typedef logic [7:0]                   len_t;
   // log2 of bytes per beat
   typedef logic [2:0]                   size_t;
   typedef logic [1:0]                   resp_t;

   typedef enum logic [1:0] {WR_IDLE, WR_DATA, WR_REQ, WR_RESP} wr_state_e;
   typedef enum logic [1:0] {RD_IDLE, RD_REQ, RD_WAIT, RD_BEAT} rd_state_e;
   typedef enum logic [1:0] {GNT_NONE, GNT_WR, GNT_RD} grant_e;

endpackage

//--- src/axi_wr_burst.sv
/*
 * AXI4 write burst engine
 * splits each write burst into single-beat IOb write requests,
 * skips all-zero strobe beats and returns one B per burst
 */
`timescale 1ns/10ps

module axi_wr_burst (
   input  logic               clk_i,
   input  logic               arst_i,
   input  axi2iob_pkg::id_t   awid_i,
   input  axi2iob_pkg::addr_t awaddr_i,
   input  axi2iob_pkg::len_t  awlen_i,
   input  axi2iob_pkg::size_t awsize_i,
   input  logic               awvalid_i,
   output logic               awready_o,
   input  axi2iob_pkg::data_t wdata_i,
   input  axi2iob_pkg::strb_t wstrb_i,
   input  logic               wvalid_i,
   output logic               wready_o,
   output axi2iob_pkg::id_t   bid_o,
   output axi2iob_pkg::resp_t bresp_o,
   output logic               bvalid_o,
   input  logic               bready_i,
   output logic               wr_req_o,
   output axi2iob_pkg::addr_t wr_addr_o,
   output axi2iob_pkg::data_t wr_data_o,
   output axi2iob_pkg::strb_t wr_strb_o,
   input  logic               wr_ack_i
);

   axi2iob_pkg::wr_state_e state_q;
   axi2iob_pkg::wr_state_e state_d;
   logic                   awready_q;

   axi2iob_pkg::id_t       id_q;
   axi2iob_pkg::addr_t     addr_q;
   axi2iob_pkg::size_t     size_q;
   axi2iob_pkg::len_t      cnt_q;
   axi2iob_pkg::data_t     data_q;
   axi2iob_pkg::strb_t     strb_q;

   logic                   aw_hs;
   logic                   w_hs;
   logic                   w_skip;
   logic                   beat_done;
   logic                   last_beat;

   assign aw_hs     = awready_q & awvalid_i;
   assign w_hs      = wready_o & wvalid_i;
   // a beat with no enabled byte never reaches the IOb side
   assign w_skip    = w_hs & ~(|wstrb_i);
   assign beat_done = w_skip | (wr_req_o & wr_ack_i);
   assign last_beat = (cnt_q == '0);

   always_comb begin
      state_d = state_q;
      case (state_q)
         axi2iob_pkg::WR_IDLE: begin
            if (aw_hs) begin
               state_d = axi2iob_pkg::WR_DATA;
            end
         end
         axi2iob_pkg::WR_DATA: begin
            if (w_hs && (|wstrb_i)) begin
               state_d = axi2iob_pkg::WR_REQ;
            end else if (w_skip && last_beat) begin
               state_d = axi2iob_pkg::WR_RESP;
            end
         end
         axi2iob_pkg::WR_REQ: begin
            if (wr_ack_i) begin
               if (last_beat) begin
                  state_d = axi2iob_pkg::WR_RESP;
               end else begin
                  state_d = axi2iob_pkg::WR_DATA;
               end
            end
         end
         axi2iob_pkg::WR_RESP: begin
            if (bready_i) begin
               state_d = axi2iob_pkg::WR_IDLE;
            end
         end
         default: state_d = axi2iob_pkg::WR_IDLE;
      endcase
   end

   always_ff @(posedge clk_i or posedge arst_i) begin
      if (arst_i) begin
         state_q   <= axi2iob_pkg::WR_IDLE;
         awready_q <= 1'b0;
      end else begin
         state_q   <= state_d;
         awready_q <= (state_d == axi2iob_pkg::WR_IDLE);
      end
   end

   // burst context and the beat waiting for the IOb
   always_ff @(posedge clk_i) begin
      if (aw_hs) begin
         id_q   <= awid_i;
         addr_q <= awaddr_i;
         size_q <= awsize_i;
         cnt_q  <= awlen_i;
      end
      if (w_hs) begin
         data_q <= wdata_i;
         strb_q <= wstrb_i;
      end
      if (beat_done) begin
         addr_q <= addr_q + (axi2iob_pkg::addr_t'(1) << size_q);
         cnt_q  <= cnt_q - 8'd1;
      end
   end

   assign awready_o = awready_q;
   assign wready_o  = (state_q == axi2iob_pkg::WR_DATA);
   assign wr_req_o  = (state_q == axi2iob_pkg::WR_REQ);
   assign bvalid_o  = (state_q == axi2iob_pkg::WR_RESP);

   assign wr_addr_o = addr_q;
   assign wr_data_o = data_q;
   assign wr_strb_o = strb_q;
   assign bid_o     = id_q;
   assign bresp_o   = '0;

endmodule

//--- src/axi_rd_burst.sv
/*
 * AXI4 read burst engine
 * issues one IOb read per beat and returns each word on R,
 * with rlast on the final beat
 */
`timescale 1ns/10ps

module axi_rd_burst (
   input  logic               clk_i,
   input  logic               arst_i,
   input  axi2iob_pkg::id_t   arid_i,
   input  axi2iob_pkg::addr_t araddr_i,
   input  axi2iob_pkg::len_t  arlen_i,
   input  axi2iob_pkg::size_t arsize_i,
   input  logic               arvalid_i,
   output logic               arready_o,
   output axi2iob_pkg::id_t   rid_o,
   output axi2iob_pkg::data_t rdata_o,
   output axi2iob_pkg::resp_t rresp_o,
   output logic               rlast_o,
   output logic               rvalid_o,
   input  logic               rready_i,
   output logic               rd_req_o,
   output axi2iob_pkg::addr_t rd_addr_o,
   input  logic               rd_ack_i,
   input  logic               iob_rvalid_i,
   input  axi2iob_pkg::data_t iob_rdata_i
);

   axi2iob_pkg::rd_state_e state_q;
   axi2iob_pkg::rd_state_e state_d;
   logic                   arready_q;

   axi2iob_pkg::id_t       id_q;
   axi2iob_pkg::addr_t     addr_q;
   axi2iob_pkg::size_t     size_q;
   axi2iob_pkg::len_t      cnt_q;
   axi2iob_pkg::data_t     rdata_q;

   logic                   ar_hs;
   logic                   r_hs;
   logic                   capture;
   logic                   last_beat;

   assign ar_hs     = arready_q & arvalid_i;
   assign r_hs      = rvalid_o & rready_i;
   // read data may come back in the same cycle the IOb accepts the access
   assign capture   = iob_rvalid_i & ((rd_req_o & rd_ack_i) |
                                      (state_q == axi2iob_pkg::RD_WAIT));
   assign last_beat = (cnt_q == '0);

   always_comb begin
      state_d = state_q;
      case (state_q)
         axi2iob_pkg::RD_IDLE: begin
            if (ar_hs) begin
               state_d = axi2iob_pkg::RD_REQ;
            end
         end
         axi2iob_pkg::RD_REQ: begin
            if (capture) begin
               state_d = axi2iob_pkg::RD_BEAT;
            end else if (rd_ack_i) begin
               state_d = axi2iob_pkg::RD_WAIT;
            end
         end
         axi2iob_pkg::RD_WAIT: begin
            if (capture) begin
               state_d = axi2iob_pkg::RD_BEAT;
            end
         end
         axi2iob_pkg::RD_BEAT: begin
            if (r_hs) begin
               if (last_beat) begin
                  state_d = axi2iob_pkg::RD_IDLE;
               end else begin
                  state_d = axi2iob_pkg::RD_REQ;
               end
            end
         end
         default: state_d = axi2iob_pkg::RD_IDLE;
      endcase
   end

   always_ff @(posedge clk_i or posedge arst_i) begin
      if (arst_i) begin
         state_q   <= axi2iob_pkg::RD_IDLE;
         arready_q <= 1'b0;
      end else begin
         state_q   <= state_d;
         arready_q <= (state_d == axi2iob_pkg::RD_IDLE);
      end
   end

   always_ff @(posedge clk_i) begin
      if (ar_hs) begin
         id_q   <= arid_i;
         addr_q <= araddr_i;
         size_q <= arsize_i;
         cnt_q  <= arlen_i;
      end
      if (capture) begin
         rdata_q <= iob_rdata_i;
      end
      // advance to the next beat once R is taken
      if (r_hs) begin
         addr_q <= addr_q + (axi2iob_pkg::addr_t'(1) << size_q);
         cnt_q  <= cnt_q - 8'd1;
      end
   end

   assign arready_o = arready_q;
   assign rd_req_o  = (state_q == axi2iob_pkg::RD_REQ);
   assign rd_addr_o = addr_q;

   assign rvalid_o  = (state_q == axi2iob_pkg::RD_BEAT);
   assign rid_o     = id_q;
   assign rdata_o   = rdata_q;
   assign rresp_o   = '0;
   assign rlast_o   = last_beat;

endmodule

//--- src/iob_req_arb.sv
/*
 * IOb request arbiter
 * grants the single IOb port to the read or write engine and
 * holds the grant until the IOb accepts the owner's access
 */
`timescale 1ns/10ps

module iob_req_arb (
   input  logic               clk_i,
   input  logic               arst_i,
   input  logic               wr_req_i,
   input  axi2iob_pkg::addr_t wr_addr_i,
   input  axi2iob_pkg::data_t wr_data_i,
   input  axi2iob_pkg::strb_t wr_strb_i,
   output logic               wr_ack_o,
   input  logic               rd_req_i,
   input  axi2iob_pkg::addr_t rd_addr_i,
   output logic               rd_ack_o,
   output logic               iob_valid_o,
   output axi2iob_pkg::addr_t iob_addr_o,
   output axi2iob_pkg::data_t iob_wdata_o,
   output axi2iob_pkg::strb_t iob_wstrb_o,
   input  logic               iob_ready_i
);

   axi2iob_pkg::grant_e grant_q;
   axi2iob_pkg::grant_e owner;

   // a held grant wins before read priority applies
   always_comb begin
      owner = grant_q;
      if (grant_q == axi2iob_pkg::GNT_NONE) begin
         if (rd_req_i) begin
            owner = axi2iob_pkg::GNT_RD;
         end else if (wr_req_i) begin
            owner = axi2iob_pkg::GNT_WR;
         end
      end
   end

   always_ff @(posedge clk_i or posedge arst_i) begin
      if (arst_i) begin
         grant_q <= axi2iob_pkg::GNT_NONE;
      end else if (iob_ready_i) begin
         grant_q <= axi2iob_pkg::GNT_NONE;
      end else begin
         grant_q <= owner;
      end
   end

   assign iob_valid_o = (owner != axi2iob_pkg::GNT_NONE);
   assign iob_addr_o  = (owner == axi2iob_pkg::GNT_RD) ? rd_addr_i : wr_addr_i;
   // reads carry an all-zero strobe and no write data
   assign iob_wdata_o = (owner == axi2iob_pkg::GNT_WR) ? wr_data_i : '0;
   assign iob_wstrb_o = (owner == axi2iob_pkg::GNT_WR) ? wr_strb_i : '0;

   assign wr_ack_o    = iob_ready_i & (owner == axi2iob_pkg::GNT_WR);
   assign rd_ack_o    = iob_ready_i & (owner == axi2iob_pkg::GNT_RD);

endmodule

//--- src/axi2iob.sv
/*
 * AXI4 slave to IOb master adapter
 * write and read burst engines share one IOb port through an arbiter
 */
`timescale 1ns/10ps

module axi2iob (
   input  logic               clk_i,
   input  logic               arst_i,

   input  axi2iob_pkg::id_t   s_axi_awid_i,
   input  axi2iob_pkg::addr_t s_axi_awaddr_i,
   input  axi2iob_pkg::len_t  s_axi_awlen_i,
   input  axi2iob_pkg::size_t s_axi_awsize_i,
   input  logic               s_axi_awvalid_i,
   output logic               s_axi_awready_o,
   input  axi2iob_pkg::data_t s_axi_wdata_i,
   input  axi2iob_pkg::strb_t s_axi_wstrb_i,
   input  logic               s_axi_wlast_i,
   input  logic               s_axi_wvalid_i,
   output logic               s_axi_wready_o,
   output axi2iob_pkg::id_t   s_axi_bid_o,
   output axi2iob_pkg::resp_t s_axi_bresp_o,
   output logic               s_axi_bvalid_o,
   input  logic               s_axi_bready_i,
   input  axi2iob_pkg::id_t   s_axi_arid_i,
   input  axi2iob_pkg::addr_t s_axi_araddr_i,
   input  axi2iob_pkg::len_t  s_axi_arlen_i,
   input  axi2iob_pkg::size_t s_axi_arsize_i,
   input  logic               s_axi_arvalid_i,
   output logic               s_axi_arready_o,
   output axi2iob_pkg::id_t   s_axi_rid_o,
   output axi2iob_pkg::data_t s_axi_rdata_o,
   output axi2iob_pkg::resp_t s_axi_rresp_o,
   output logic               s_axi_rlast_o,
   output logic               s_axi_rvalid_o,
   input  logic               s_axi_rready_i,

   output logic               iob_valid_o,
   output axi2iob_pkg::addr_t iob_addr_o,
   output axi2iob_pkg::data_t iob_wdata_o,
   output axi2iob_pkg::strb_t iob_wstrb_o,
   input  logic               iob_ready_i,
   input  logic               iob_rvalid_i,
   input  axi2iob_pkg::data_t iob_rdata_i
);

   // engine requests toward the arbiter
   logic               wr_req;
   axi2iob_pkg::addr_t wr_addr;
   axi2iob_pkg::data_t wr_data;
   axi2iob_pkg::strb_t wr_strb;
   logic               wr_ack;
   logic               rd_req;
   axi2iob_pkg::addr_t rd_addr;
   logic               rd_ack;

   // s_axi_wlast_i stays unconnected because awlen sets the beat count
   axi_wr_burst wr_burst_i (
      .clk_i    (clk_i),
      .arst_i   (arst_i),
      .awid_i   (s_axi_awid_i),
      .awaddr_i (s_axi_awaddr_i),
      .awlen_i  (s_axi_awlen_i),
      .awsize_i (s_axi_awsize_i),
      .awvalid_i(s_axi_awvalid_i),
      .awready_o(s_axi_awready_o),
      .wdata_i  (s_axi_wdata_i),
      .wstrb_i  (s_axi_wstrb_i),
      .wvalid_i (s_axi_wvalid_i),
      .wready_o (s_axi_wready_o),
      .bid_o    (s_axi_bid_o),
      .bresp_o  (s_axi_bresp_o),
      .bvalid_o (s_axi_bvalid_o),
      .bready_i (s_axi_bready_i),
      .wr_req_o (wr_req),
      .wr_addr_o(wr_addr),
      .wr_data_o(wr_data),
      .wr_strb_o(wr_strb),
      .wr_ack_i (wr_ack)
   );

   axi_rd_burst rd_burst_i (
      .clk_i       (clk_i),
      .arst_i      (arst_i),
      .arid_i      (s_axi_arid_i),
      .araddr_i    (s_axi_araddr_i),
      .arlen_i     (s_axi_arlen_i),
      .arsize_i    (s_axi_arsize_i),
      .arvalid_i   (s_axi_arvalid_i),
      .arready_o   (s_axi_arready_o),
      .rid_o       (s_axi_rid_o),
      .rdata_o     (s_axi_rdata_o),
      .rresp_o     (s_axi_rresp_o),
      .rlast_o     (s_axi_rlast_o),
      .rvalid_o    (s_axi_rvalid_o),
      .rready_i    (s_axi_rready_i),
      .rd_req_o    (rd_req),
      .rd_addr_o   (rd_addr),
      .rd_ack_i    (rd_ack),
      .iob_rvalid_i(iob_rvalid_i),
      .iob_rdata_i (iob_rdata_i)
   );

   iob_req_arb req_arb_i (
      .clk_i      (clk_i),
      .arst_i     (arst_i),
      .wr_req_i   (wr_req),
      .wr_addr_i  (wr_addr),
      .wr_data_i  (wr_data),
      .wr_strb_i  (wr_strb),
      .wr_ack_o   (wr_ack),
      .rd_req_i   (rd_req),
      .rd_addr_i  (rd_addr),
      .rd_ack_o   (rd_ack),
      .iob_valid_o(iob_valid_o),
      .iob_addr_o (iob_addr_o),
      .iob_wdata_o(iob_wdata_o),
      .iob_wstrb_o(iob_wstrb_o),
      .iob_ready_i(iob_ready_i)
   );

endmodule

//--- testbench/tb_axi2iob.sv
/*
 * testbench for the AXI4 to IOb adapter
 * random AXI master, IOb memory responder and a reference model
 */
`timescale 1ns/10ps

module tb_axi2iob;

   localparam int NUM_BURSTS = 40;
   localparam int MAX_CYCLES = NUM_BURSTS * 8 * 40;
   localparam int NB         = $bits(axi2iob_pkg::strb_t);

   logic               clk_i;
   logic               arst_i;
   axi2iob_pkg::id_t   s_axi_awid_i;
   axi2iob_pkg::addr_t s_axi_awaddr_i;
   axi2iob_pkg::len_t  s_axi_awlen_i;
   axi2iob_pkg::size_t s_axi_awsize_i;
   logic               s_axi_awvalid_i;
   logic               s_axi_awready_o;
   axi2iob_pkg::data_t s_axi_wdata_i;
   axi2iob_pkg::strb_t s_axi_wstrb_i;
   logic               s_axi_wlast_i;
   logic               s_axi_wvalid_i;
   logic               s_axi_wready_o;
   axi2iob_pkg::id_t   s_axi_bid_o;
   axi2iob_pkg::resp_t s_axi_bresp_o;
   logic               s_axi_bvalid_o;
   logic               s_axi_bready_i;
   axi2iob_pkg::id_t   s_axi_arid_i;
   axi2iob_pkg::addr_t s_axi_araddr_i;
   axi2iob_pkg::len_t  s_axi_arlen_i;
   axi2iob_pkg::size_t s_axi_arsize_i;
   logic               s_axi_arvalid_i;
   logic               s_axi_arready_o;
   axi2iob_pkg::id_t   s_axi_rid_o;
   axi2iob_pkg::data_t s_axi_rdata_o;
   axi2iob_pkg::resp_t s_axi_rresp_o;
   logic               s_axi_rlast_o;
   logic               s_axi_rvalid_o;
   logic               s_axi_rready_i;
   logic               iob_valid_o;
   axi2iob_pkg::addr_t iob_addr_o;
   axi2iob_pkg::data_t iob_wdata_o;
   axi2iob_pkg::strb_t iob_wstrb_o;
   logic               iob_ready_i;
   logic               iob_rvalid_i;
   axi2iob_pkg::data_t iob_rdata_i;

   logic [31:0]        lfsr_q = 32'hcccdbe9b;
   int                 cycles = 0;

   // memory seen by the IOb side and the model's own copy
   logic [7:0]         iob_mem [axi2iob_pkg::addr_t];
   logic [7:0]         model_mem [axi2iob_pkg::addr_t];

   axi2iob_pkg::addr_t exp_wr_addr [$];
   axi2iob_pkg::data_t exp_wr_data [$];
   axi2iob_pkg::strb_t exp_wr_strb [$];
   axi2iob_pkg::addr_t exp_rd_addr [$];

   // write bursts kept so that later reads can revisit them
   axi2iob_pkg::addr_t wr_log_addr [NUM_BURSTS];
   axi2iob_pkg::len_t  wr_log_len  [NUM_BURSTS];
   axi2iob_pkg::size_t wr_log_size [NUM_BURSTS];

   axi2iob axi2iob_i (.*);

   always #5 clk_i = ~clk_i;

   always @(posedge clk_i) begin
      cycles = cycles + 1;
      if (cycles > MAX_CYCLES) begin
         stop_run("timeout: the bursts did not complete within the cycle limit");
      end
   end

   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      logic fb;
      fb = s[31] ^ s[21] ^ s[1] ^ s[0];
      return {s[30:0], fb};
   endfunction

   // one LFSR step per bit taken
   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] r;
      r = '0;
      for (int k = 0; k < n; k++) begin
         lfsr_q = lfsr_next(lfsr_q);
         r = {r[30:0], lfsr_q[0]};
      end
      return r;
   endfunction

   function automatic logic [7:0] fill_byte(input axi2iob_pkg::addr_t a);
      return a[7:0] ^ a[15:8] ^ a[23:16] ^ a[31:24] ^ 8'h5a;
   endfunction

   function automatic axi2iob_pkg::data_t mem_word(input axi2iob_pkg::addr_t a,
                                                  input bit from_model);
      axi2iob_pkg::data_t w;
      axi2iob_pkg::addr_t ba;
      w = '0;
      for (int k = 0; k < NB; k++) begin
         ba = (a & ~axi2iob_pkg::addr_t'(NB - 1)) + axi2iob_pkg::addr_t'(k);
         if (from_model) begin
            w[k*8 +: 8] = model_mem.exists(ba) ? model_mem[ba] : fill_byte(ba);
         end else begin
            w[k*8 +: 8] = iob_mem.exists(ba) ? iob_mem[ba] : fill_byte(ba);
         end
      end
      return w;
   endfunction

   task automatic stop_run(input string why);
      $display("%s", why);
      $display("Test failed");
      $fatal(1);
   endtask

   task automatic check_req(input string name,
                            input axi2iob_pkg::addr_t ea, input axi2iob_pkg::data_t ed,
                            input axi2iob_pkg::strb_t es,
                            input axi2iob_pkg::addr_t aa, input axi2iob_pkg::data_t ad,
                            input axi2iob_pkg::strb_t as, input bit with_data);
      if (ea !== aa || es !== as || (with_data && ed !== ad)) begin
         $display("FAIL %s: expected addr %h data %h strb %h, actual addr %h data %h strb %h",
                  name, ea, ed, es, aa, ad, as);
         stop_run("IOb request mismatch");
      end
   endtask

   task automatic check_b(input string name,
                          input axi2iob_pkg::id_t eid, input axi2iob_pkg::resp_t eresp,
                          input axi2iob_pkg::id_t aid, input axi2iob_pkg::resp_t aresp);
      if (eid !== aid || eresp !== aresp) begin
         $display("FAIL %s: expected bid %h bresp %h, actual bid %h bresp %h",
                  name, eid, eresp, aid, aresp);
         stop_run("B response mismatch");
      end
   endtask

   task automatic check_r(input string name,
                          input axi2iob_pkg::id_t eid, input axi2iob_pkg::data_t edata,
                          input axi2iob_pkg::resp_t eresp, input bit elast,
                          input axi2iob_pkg::id_t aid, input axi2iob_pkg::data_t adata,
                          input axi2iob_pkg::resp_t aresp, input bit alast);
      if (eid !== aid || edata !== adata || eresp !== aresp || elast !== alast) begin
         $display("FAIL %s: expected rid %h rdata %h rresp %h rlast %b, actual %h %h %h %b",
                  name, eid, edata, eresp, elast, aid, adata, aresp, alast);
         stop_run("R beat mismatch");
      end
   endtask

   task automatic check_ctrl_low(input string when);
      if (s_axi_awready_o || s_axi_wready_o || s_axi_bvalid_o || s_axi_arready_o ||
          s_axi_rvalid_o || iob_valid_o) begin
         stop_run({"a control output was high ", when});
      end
   endtask

   task automatic write_burst(input int iter);
      axi2iob_pkg::id_t   id;
      axi2iob_pkg::addr_t addr;
      axi2iob_pkg::addr_t ba;
      axi2iob_pkg::len_t  len;
      axi2iob_pkg::size_t size;
      axi2iob_pkg::data_t data;
      axi2iob_pkg::strb_t strb;
      axi2iob_pkg::id_t   prev_id;
      bit                 hold;
      bit                 done;
      id   = axi2iob_pkg::id_t'(rand_bits(8));
      len  = axi2iob_pkg::len_t'(rand_bits(3));
      size = axi2iob_pkg::size_t'(int'(rand_bits(2)) % 3);
      addr = axi2iob_pkg::addr_t'(32'h1000 * (iter + 1)) | axi2iob_pkg::addr_t'(rand_bits(8));
      wr_log_addr[iter] = addr;
      wr_log_len[iter]  = len;
      wr_log_size[iter] = size;

      @(posedge clk_i);
      #1;
      s_axi_awid_i    = id;
      s_axi_awaddr_i  = addr;
      s_axi_awlen_i   = len;
      s_axi_awsize_i  = size;
      s_axi_awvalid_i = 1'b1;
      @(negedge clk_i);
      while (!s_axi_awready_o) @(negedge clk_i);
      @(posedge clk_i);
      #1;
      s_axi_awvalid_i = 1'b0;

      for (int b = 0; b <= int'(len); b++) begin
         if (rand_bits(2) == 32'd0) begin
            @(posedge clk_i);
            #1;
         end
         data = rand_bits(32);
         strb = axi2iob_pkg::strb_t'(rand_bits(NB));
         if (strb == '0) begin
            strb = '1;
         end
         // about one beat in eight carries no enabled byte
         if (rand_bits(3) == 32'd0) begin
            strb = '0;
         end
         ba = addr + (axi2iob_pkg::addr_t'(b) << size);
         s_axi_wdata_i  = data;
         s_axi_wstrb_i  = strb;
         s_axi_wlast_i  = (b == int'(len));
         s_axi_wvalid_i = 1'b1;
         @(negedge clk_i);
         while (!s_axi_wready_o) @(negedge clk_i);
         if (strb != '0) begin
            exp_wr_addr.push_back(ba);
            exp_wr_data.push_back(data);
            exp_wr_strb.push_back(strb);
            for (int k = 0; k < NB; k++) begin
               if (strb[k]) begin
                  model_mem[(ba & ~axi2iob_pkg::addr_t'(NB - 1)) + axi2iob_pkg::addr_t'(k)] =
                     data[k*8 +: 8];
               end
            end
         end
         @(posedge clk_i);
         #1;
         s_axi_wvalid_i = 1'b0;
      end

      hold = 1'b0;
      done = 1'b0;
      prev_id = '0;
      while (!done) begin
         s_axi_bready_i = rand_bits(1) != 32'd0;
         @(negedge clk_i);
         if (s_axi_bvalid_o) begin
            if (exp_wr_addr.size() != 0) begin
               stop_run("B was raised before all IOb writes of the burst were accepted");
            end
            if (hold) begin
               check_b("b hold", prev_id, '0, s_axi_bid_o, s_axi_bresp_o);
            end
            if (s_axi_bready_i) begin
               check_b("write response", id, '0, s_axi_bid_o, s_axi_bresp_o);
               done = 1'b1;
            end else begin
               hold    = 1'b1;
               prev_id = s_axi_bid_o;
            end
         end else if (hold) begin
            stop_run("bvalid dropped before bready");
         end
         @(posedge clk_i);
         #1;
      end
      s_axi_bready_i = 1'b0;
   endtask

   task automatic read_burst(input int iter);
      axi2iob_pkg::id_t   id;
      axi2iob_pkg::addr_t addr;
      axi2iob_pkg::len_t  len;
      axi2iob_pkg::size_t size;
      axi2iob_pkg::id_t   prev_id;
      axi2iob_pkg::data_t prev_data;
      bit                 prev_last;
      bit                 hold;
      int                 beat;
      id = axi2iob_pkg::id_t'(rand_bits(8));
      // either revisit the previous write burst or read untouched memory
      if (iter > 0 && rand_bits(1) != 32'd0) begin
         addr = wr_log_addr[iter-1];
         len  = wr_log_len[iter-1];
         size = wr_log_size[iter-1];
      end else begin
         addr = 32'h8000_0000 | axi2iob_pkg::addr_t'(rand_bits(12));
         len  = axi2iob_pkg::len_t'(rand_bits(3));
         size = axi2iob_pkg::size_t'(int'(rand_bits(2)) % 3);
      end

      @(posedge clk_i);
      #1;
      s_axi_arid_i    = id;
      s_axi_araddr_i  = addr;
      s_axi_arlen_i   = len;
      s_axi_arsize_i  = size;
      s_axi_arvalid_i = 1'b1;
      @(negedge clk_i);
      while (!s_axi_arready_o) @(negedge clk_i);
      for (int b = 0; b <= int'(len); b++) begin
         exp_rd_addr.push_back(addr + (axi2iob_pkg::addr_t'(b) << size));
      end
      @(posedge clk_i);
      #1;
      s_axi_arvalid_i = 1'b0;

      beat      = 0;
      hold      = 1'b0;
      prev_id   = '0;
      prev_data = '0;
      prev_last = 1'b0;
      while (beat <= int'(len)) begin
         s_axi_rready_i = rand_bits(1) != 32'd0;
         @(negedge clk_i);
         if (s_axi_rvalid_o) begin
            if (hold) begin
               check_r("r hold", prev_id, prev_data, '0, prev_last,
                       s_axi_rid_o, s_axi_rdata_o, s_axi_rresp_o, s_axi_rlast_o);
            end
            if (s_axi_rready_i) begin
               check_r("read beat", id,
                       mem_word(addr + (axi2iob_pkg::addr_t'(beat) << size), 1'b1),
                       '0, beat == int'(len),
                       s_axi_rid_o, s_axi_rdata_o, s_axi_rresp_o, s_axi_rlast_o);
               beat = beat + 1;
               hold = 1'b0;
            end else begin
               hold      = 1'b1;
               prev_id   = s_axi_rid_o;
               prev_data = s_axi_rdata_o;
               prev_last = s_axi_rlast_o;
            end
         end else if (hold) begin
            stop_run("rvalid dropped before rready");
         end
         @(posedge clk_i);
         #1;
      end
      s_axi_rready_i = 1'b0;
   endtask

   // IOb memory responder with random ready and read latency
   initial begin : iob_responder
      axi2iob_pkg::addr_t ea;
      axi2iob_pkg::data_t ed;
      axi2iob_pkg::strb_t es;
      axi2iob_pkg::addr_t ha;
      axi2iob_pkg::data_t hd;
      axi2iob_pkg::strb_t hs;
      axi2iob_pkg::data_t rd_word;
      bit                 hold;
      int                 rd_delay;
      int                 d;
      hold     = 1'b0;
      rd_delay = 0;
      rd_word  = '0;
      @(negedge arst_i);
      forever begin
         @(posedge clk_i);
         #1;
         iob_rvalid_i = 1'b0;
         if (rd_delay > 0) begin
            rd_delay = rd_delay - 1;
            if (rd_delay == 0) begin
               iob_rvalid_i = 1'b1;
               iob_rdata_i  = rd_word;
            end
         end
         iob_ready_i = rand_bits(2) != 32'd0;
         #1;
         if (hold) begin
            if (!iob_valid_o) begin
               stop_run("iob_valid_o dropped before the access was accepted");
            end
            check_req("iob hold", ha, hd, hs, iob_addr_o, iob_wdata_o, iob_wstrb_o, 1'b1);
         end
         hold = 1'b0;
         if (iob_valid_o && !iob_ready_i) begin
            hold = 1'b1;
            ha   = iob_addr_o;
            hd   = iob_wdata_o;
            hs   = iob_wstrb_o;
         end else if (iob_valid_o && iob_wstrb_o == '0) begin
            if (exp_rd_addr.size() == 0) begin
               stop_run("an IOb read appeared that no read burst asked for");
            end
            ea = exp_rd_addr.pop_front();
            check_req("iob read", ea, '0, '0, iob_addr_o, iob_wdata_o, iob_wstrb_o, 1'b0);
            rd_word = mem_word(iob_addr_o, 1'b0);
            d = int'(rand_bits(2)) % 3;
            if (d == 0) begin
               iob_rvalid_i = 1'b1;
               iob_rdata_i  = rd_word;
            end else begin
               rd_delay = d;
            end
         end else if (iob_valid_o) begin
            if (exp_wr_addr.size() == 0) begin
               stop_run("an IOb write appeared that no write beat asked for");
            end
            ea = exp_wr_addr.pop_front();
            ed = exp_wr_data.pop_front();
            es = exp_wr_strb.pop_front();
            check_req("iob write", ea, ed, es, iob_addr_o, iob_wdata_o, iob_wstrb_o, 1'b1);
            for (int k = 0; k < NB; k++) begin
               if (iob_wstrb_o[k]) begin
                  iob_mem[(iob_addr_o & ~axi2iob_pkg::addr_t'(NB - 1)) +
                          axi2iob_pkg::addr_t'(k)] = iob_wdata_o[k*8 +: 8];
               end
            end
         end
      end
   end

   initial begin : main_seq
      clk_i           = 1'b0;
      arst_i          = 1'b1;
      s_axi_awid_i    = '0;
      s_axi_awaddr_i  = '0;
      s_axi_awlen_i   = '0;
      s_axi_awsize_i  = '0;
      s_axi_awvalid_i = 1'b0;
      s_axi_wdata_i   = '0;
      s_axi_wstrb_i   = '0;
      s_axi_wlast_i   = 1'b0;
      s_axi_wvalid_i  = 1'b0;
      s_axi_bready_i  = 1'b0;
      s_axi_arid_i    = '0;
      s_axi_araddr_i  = '0;
      s_axi_arlen_i   = '0;
      s_axi_arsize_i  = '0;
      s_axi_arvalid_i = 1'b0;
      s_axi_rready_i  = 1'b0;
      iob_ready_i     = 1'b0;
      iob_rvalid_i    = 1'b0;
      iob_rdata_i     = '0;

      repeat (4) begin
         @(negedge clk_i);
         check_ctrl_low("during reset");
      end
      @(posedge clk_i);
      #1;
      arst_i = 1'b0;
      @(negedge clk_i);
      check_ctrl_low("on the first edge after reset");
      @(negedge clk_i);
      if (!s_axi_awready_o || !s_axi_arready_o) begin
         stop_run("awready or arready did not rise after reset");
      end

      // each round runs one write burst and one read burst side by side
      for (int i = 0; i < NUM_BURSTS; i++) begin
         fork
            write_burst(i);
            read_burst(i);
         join
      end
      repeat (5) @(posedge clk_i);

      if (exp_wr_addr.size() == 0 && exp_rd_addr.size() == 0) begin
         $display("Test passed");
         $finish;
      end else begin
         stop_run("some expected IOb requests never appeared");
      end
   end

endmodule

//--- src.f
+incdir+include
src/axi2iob_pkg.sv
src/axi_wr_burst.sv
src/axi_rd_burst.sv
src/iob_req_arb.sv
src/axi2iob.sv
testbench/tb_axi2iob.sv

//--- run.sh
#!/bin/sh
# build and run the axi2iob testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f src.f --top-module tb_axi2iob -o sim_axi2iob

out=$(./obj_dir/sim_axi2iob 2>&1) || true
echo "$out"

# the run passes only if the pass message was printed
echo "$out" | grep -q "Test passed"
